//--- source/fxmac_pkg.sv
package fxmac_pkg;

  // operand and product widths
  localparam int OPERAND_W = 16;
  localparam int PRODUCT_W = 16;
  localparam int ACC_W = 24;

  // signed input operand, used for both a and b
  typedef logic signed [OPERAND_W-1:0] operand_t;

  // exact product before realignment
  typedef logic signed [2*OPERAND_W-1:0] full_product_t;

  // product realigned to the output fractional format
  typedef logic signed [PRODUCT_W-1:0] product_t;

  // block accumulator, 8 guard bits cover 256 products
  typedef logic signed [ACC_W-1:0] acc_t;

  // saturated block sum
  typedef logic signed [PRODUCT_W-1:0] result_t;

  typedef enum logic {
    summing,
    holding
  } acc_state_e;

endpackage

//--- source/frac_mult_stage.sv
module frac_mult_stage #(
  parameter int FRAC_BITS_A = 4,
  parameter int FRAC_BITS_B = 4,
  parameter int FRAC_BITS_OUT = 8
) (
  input  logic                clk,
  input  logic                reset,
  input  logic                in_valid,
  output logic                in_ready,
  input  fxmac_pkg::operand_t in_a,
  input  fxmac_pkg::operand_t in_b,
  output logic                prod_valid,
  input  logic                prod_ready,
  output fxmac_pkg::product_t prod_data
);

  // binary point moves by this many bits from product to output
  localparam int SHIFT = FRAC_BITS_A + FRAC_BITS_B - FRAC_BITS_OUT;

  fxmac_pkg::full_product_t full_product;
  fxmac_pkg::full_product_t aligned_product;
  logic                     accept;

  // exact signed product of the operand pair
  assign full_product = in_a * in_b;

  // arithmetic shift keeps the sign, low bits are kept below (wraps)
  assign aligned_product = full_product >>> SHIFT;

  // output register empty or draining this cycle
  assign in_ready = !prod_valid || prod_ready;
  assign accept = in_valid && in_ready;

  always_ff @(posedge clk) begin
    if (reset) begin
      prod_valid <= 1'b0;
    end else if (in_ready) begin
      prod_valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      prod_data <= aligned_product[fxmac_pkg::PRODUCT_W-1:0];
    end
  end

  // a stalled product must not change or disappear before the FIFO takes it
  a_prod_stable: assert property (
    @(posedge clk) disable iff (reset)
    prod_valid && !prod_ready |=> prod_valid && $stable(prod_data)
  ) else $error("frac_mult_stage: prod_data changed under back-pressure");

  // output format may not carry more fraction bits than the raw product
  a_shift_non_negative: assert property (
    @(posedge clk) SHIFT >= 0
  ) else $error("frac_mult_stage: negative realignment shift");

endmodule

//--- source/sample_fifo.sv
module sample_fifo #(
  parameter int FIFO_DEPTH = 8
) (
  input  logic                clk,
  input  logic                reset,
  input  logic                prod_valid,
  output logic                prod_ready,
  input  fxmac_pkg::product_t prod_data,
  output logic                fifo_valid,
  input  logic                fifo_ready,
  output fxmac_pkg::product_t fifo_data
);

  localparam int PTR_W = $clog2(FIFO_DEPTH);

  fxmac_pkg::product_t mem [FIFO_DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   count;
  logic             full;
  logic             wr_en;
  logic             rd_en;

  assign full = (count == (PTR_W + 1)'(FIFO_DEPTH));
  assign fifo_valid = (count != '0);

  // a read in the same cycle frees the slot, so a full FIFO still accepts
  assign prod_ready = !full || fifo_ready;

  assign wr_en = prod_valid && prod_ready;
  assign rd_en = fifo_valid && fifo_ready;

  // output reads straight from the head entry
  assign fifo_data = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= prod_data;
    end
  end

  // pointers wrap on their own since depth is a power of two
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  a_count_bound: assert property (
    @(posedge clk) disable iff (reset)
    count <= (PTR_W + 1)'(FIFO_DEPTH)
  ) else $error("sample_fifo: occupancy above depth");

  // a read from empty would wrap the count to all ones
  a_no_read_empty: assert property (
    @(posedge clk) disable iff (reset)
    count == '0 |=> count <= 1
  ) else $error("sample_fifo: read while empty");

endmodule

//--- source/mac_accumulator.sv
module mac_accumulator #(
  parameter int BLOCK_LEN = 4
) (
  input  logic                clk,
  input  logic                reset,
  input  logic                fifo_valid,
  output logic                fifo_ready,
  input  fxmac_pkg::product_t fifo_data,
  output logic                result_valid,
  input  logic                result_ready,
  output fxmac_pkg::result_t  result_data
);

  // counter holds 0 .. BLOCK_LEN-1
  localparam int CNT_W = $clog2(BLOCK_LEN + 1);

  // 16-bit signed limits in accumulator width
  localparam fxmac_pkg::acc_t SAT_MAX = 24'sd32767;
  localparam fxmac_pkg::acc_t SAT_MIN = -24'sd32768;

  fxmac_pkg::acc_state_e state;
  fxmac_pkg::acc_t       acc;
  fxmac_pkg::acc_t       acc_next;
  fxmac_pkg::result_t    sat_sum;
  logic [CNT_W-1:0]      cnt;
  logic                  accept;
  logic                  last;

  assign fifo_ready = (state == fxmac_pkg::summing);
  assign result_valid = (state == fxmac_pkg::holding);

  assign accept = fifo_valid && fifo_ready;
  assign last = (cnt == CNT_W'(BLOCK_LEN - 1));

  // sign-extend the product into the accumulator width
  assign acc_next = acc + fxmac_pkg::acc_t'(fifo_data);

  // clamp the finished sum
  always_comb begin
    if (acc_next > SAT_MAX) begin
      sat_sum = SAT_MAX[fxmac_pkg::PRODUCT_W-1:0];
    end else if (acc_next < SAT_MIN) begin
      sat_sum = SAT_MIN[fxmac_pkg::PRODUCT_W-1:0];
    end else begin
      sat_sum = acc_next[fxmac_pkg::PRODUCT_W-1:0];
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= fxmac_pkg::summing;
      acc   <= '0;
      cnt   <= '0;
    end else begin
      case (state)
        fxmac_pkg::summing: begin
          if (accept && last) begin
            // block done, start the next one from zero
            acc   <= '0;
            cnt   <= '0;
            state <= fxmac_pkg::holding;
          end else if (accept) begin
            acc <= acc_next;
            cnt <= cnt + 1'b1;
          end
        end
        fxmac_pkg::holding: begin
          if (result_ready) begin
            state <= fxmac_pkg::summing;
          end
        end
        default: state <= fxmac_pkg::summing;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept && last) begin
      result_data <= sat_sum;
    end
  end

  a_result_stable: assert property (
    @(posedge clk) disable iff (reset)
    result_valid && !result_ready |=> result_valid && $stable(result_data)
  ) else $error("mac_accumulator: result_data changed while waiting");

endmodule

//--- source/fxmac_top.sv
module fxmac_top #(
  parameter int FRAC_BITS_A = 4,
  parameter int FRAC_BITS_B = 4,
  parameter int FRAC_BITS_OUT = 8,
  parameter int FIFO_DEPTH = 8,
  parameter int BLOCK_LEN = 4
) (
  input  logic                clk,
  input  logic                reset,
  input  logic                in_valid,
  output logic                in_ready,
  input  fxmac_pkg::operand_t in_a,
  input  fxmac_pkg::operand_t in_b,
  output logic                result_valid,
  input  logic                result_ready,
  output fxmac_pkg::result_t  result_data
);

  // multiplier to FIFO
  logic                prod_valid;
  logic                prod_ready;
  fxmac_pkg::product_t prod_data;

  // FIFO to accumulator
  logic                fifo_valid;
  logic                fifo_ready;
  fxmac_pkg::product_t fifo_data;

  frac_mult_stage #(
    .FRAC_BITS_A   (FRAC_BITS_A),
    .FRAC_BITS_B   (FRAC_BITS_B),
    .FRAC_BITS_OUT (FRAC_BITS_OUT)
  ) u_mult (
    .clk        (clk),
    .reset      (reset),
    .in_valid   (in_valid),
    .in_ready   (in_ready),
    .in_a       (in_a),
    .in_b       (in_b),
    .prod_valid (prod_valid),
    .prod_ready (prod_ready),
    .prod_data  (prod_data)
  );

  sample_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_fifo (
    .clk        (clk),
    .reset      (reset),
    .prod_valid (prod_valid),
    .prod_ready (prod_ready),
    .prod_data  (prod_data),
    .fifo_valid (fifo_valid),
    .fifo_ready (fifo_ready),
    .fifo_data  (fifo_data)
  );

  mac_accumulator #(
    .BLOCK_LEN (BLOCK_LEN)
  ) u_acc (
    .clk          (clk),
    .reset        (reset),
    .fifo_valid   (fifo_valid),
    .fifo_ready   (fifo_ready),
    .fifo_data    (fifo_data),
    .result_valid (result_valid),
    .result_ready (result_ready),
    .result_data  (result_data)
  );

endmodule

//--- test/clock_gen.sv
module clock_gen #(
  parameter int PERIOD_NS = 20,
  parameter int RESET_CYCLES = 10
) (
  output logic clk,
  output logic reset
);
  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  // reset drops on a rising edge, like any other driven input
  initial begin
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;
  end

endmodule

//--- test/fxmac_tb.sv
module fxmac_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int BLOCK_LEN = 4;
  // result_ready stays low this long after reset so the pipeline backs up
  localparam int HOLD_CYCLES = 80;

  logic                clk;
  logic                reset;
  logic                in_valid = 1'b0;
  logic                in_ready;
  fxmac_pkg::operand_t in_a = '0;
  fxmac_pkg::operand_t in_b = '0;
  logic                result_valid;
  logic                result_ready = 1'b0;
  fxmac_pkg::result_t  result_data;

  fxmac_pkg::operand_t pair_a [$];
  fxmac_pkg::operand_t pair_b [$];
  fxmac_pkg::result_t  expected [$];

  logic [31:0] rng_state = 32'h2d8ce6bf;
  logic        pair_xfer = 1'b0;
  logic        saw_stall = 1'b0;
  int          sent = 0;
  int          got = 0;
  int          cycles = 0;
  int          checks = 0;
  int          errors = 0;
  int          load_errors = 0;
  int          limit = 0;
  int          total = 0;

  clock_gen #(.PERIOD_NS(20), .RESET_CYCLES(10)) u_clk (.clk(clk), .reset(reset));

  fxmac_top #(.BLOCK_LEN(BLOCK_LEN)) u_dut (
    .clk          (clk),
    .reset        (reset),
    .in_valid     (in_valid),
    .in_ready     (in_ready),
    .in_a         (in_a),
    .in_b         (in_b),
    .result_valid (result_valid),
    .result_ready (result_ready),
    .result_data  (result_data)
  );

  function automatic logic [31:0] next_random(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic check_value(input string name, input logic [15:0] exp_v,
                             input logic [15:0] act_v);
    checks++;
    if (act_v !== exp_v) begin
      errors++;
      $display("FAILED at %0d ns: %s expected %h got %h", $time, name, exp_v, act_v);
    end
  endtask

  // S lines carry a pair, E lines the sum of the block just listed
  task automatic read_patterns();
    int             fd;
    int             code;
    logic [7:0]     tag;
    logic [1023:0]  rest;
    logic [15:0]    a;
    logic [15:0]    b;
    fd = $fopen("test/fxmac_patterns.txt", "r");
    if (fd == 0) begin
      load_errors++;
      $display("cannot open test/fxmac_patterns.txt");
      return;
    end
    while (!$feof(fd)) begin
      code = $fscanf(fd, "%s", tag);
      if (code != 1) break;
      if (tag == "#") begin
        code = $fgets(rest, fd);
      end else if (tag == "S") begin
        code = $fscanf(fd, "%h %h", a, b);
        pair_a.push_back(a);
        pair_b.push_back(b);
      end else if (tag == "E") begin
        code = $fscanf(fd, "%h", a);
        expected.push_back(a);
      end else begin
        load_errors++;
        $display("unknown record type in the pattern file");
        break;
      end
    end
    $fclose(fd);
    if (pair_a.size() == 0 || expected.size() * BLOCK_LEN != pair_a.size()) begin
      load_errors++;
      $display("pattern file holds %0d pairs for %0d sums", pair_a.size(), expected.size());
    end
  endtask

  // inputs change on the rising edge only
  always @(posedge clk) begin
    rng_state = next_random(rng_state);
    if (reset) begin
      in_valid <= 1'b0;
      result_ready <= 1'b0;
    end else begin
      result_ready <= (cycles >= HOLD_CYCLES) && (rng_state[1:0] != 2'b00);
      if (in_valid && !pair_xfer) begin
        in_valid <= 1'b1;
      end else if (sent < pair_a.size() &&
                   (sent < BLOCK_LEN ||
                    (rng_state[4:3] != 2'b00 && !(in_valid && sent == BLOCK_LEN + 1)))) begin
        // first block back to back, later ones with random gaps and
        // always one idle cycle inside the second block
        in_valid <= 1'b1;
        in_a <= pair_a[sent];
        in_b <= pair_b[sent];
      end else begin
        in_valid <= 1'b0;
      end
    end
  end

  // handshakes sampled mid cycle, they complete on the next rising edge
  always @(negedge clk) begin
    if (!reset) begin
      cycles++;
      if (result_valid && sent < BLOCK_LEN) begin
        errors++;
        $display("result_valid high at %0t before a full block was accepted", $time);
      end
      if (result_valid && result_ready) begin
        if (got < expected.size()) begin
          check_value("result_data", expected[got], result_data);
        end else begin
          errors++;
          $display("extra result at %0t with no expected sum left", $time);
        end
        got++;
      end
      if (in_valid && !in_ready) begin
        saw_stall = 1'b1;
      end
      pair_xfer = in_valid && in_ready;
      if (pair_xfer) begin
        sent++;
      end
    end
  end

  initial begin
    read_patterns();
    limit = 64 * pair_a.size() + 200;
    while (!(sent == pair_a.size() && got >= expected.size()) && cycles < limit) begin
      @(posedge clk);
    end
    total = errors + load_errors;
    if (cycles >= limit) begin
      total++;
      $display("timeout after %0d cycles with %0d of %0d pairs sent", cycles, sent, pair_a.size());
    end
    if (got < expected.size()) begin
      total += expected.size() - got;
      $display("%0d expected sums never arrived", expected.size() - got);
    end
    if (!saw_stall) begin
      total++;
      $display("in_ready never fell while result_ready was held low");
    end
    $display("checks %0d errors %0d", checks, total);
    if (total == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

//--- fxmac.f
source/fxmac_pkg.sv
source/frac_mult_stage.sv
source/sample_fifo.sv
source/mac_accumulator.sv
source/fxmac_top.sv
test/clock_gen.sv
test/fxmac_tb.sv

//--- Makefile
# Verilator build and run for the fxmac testbench

VERILATOR ?= verilator
TOP       ?= fxmac_tb
FILELIST  ?= fxmac.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

SOURCES := $(wildcard source/*.sv test/*.sv)
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM)
	./$(SIM) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Regression failed" $(LOG); then exit 1; fi
	@grep -q "Regression passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- test/fxmac_patterns.txt
# S a b    operand pair as 16-bit hex, 4 fraction bits each
# E sum    expected saturated block sum as 16-bit hex
S 0180 0030
S ff40 0028
S 0300 0050
S ffe8 ff90
E 2480
S 0180 0030
S ff40 0028
S 0300 0050
S ffe8 ff90
E 2480
S 00e0 0080
S 0100 0070
S 0064 0064
S ff00 0010
E 7fff
S ff00 0070
S 0080 ff20
S fc00 0010
S 0020 0040
E 8000
